// ==== exu_alu.f ====
design/exu_alu_pkg.sv
design/exu_alu_rglr.sv
design/exu_alu_bjp.sv
design/exu_alu_dpath.sv
design/exu_alu_ctrl.sv
design/exu_alu_top.sv
testbench/exu_alu_tb.sv

// ==== Bender.yml ====
package:
  name: exu_alu

sources:
  - design/exu_alu_pkg.sv
  - design/exu_alu_rglr.sv
  - design/exu_alu_bjp.sv
  - design/exu_alu_dpath.sv
  - design/exu_alu_ctrl.sv
  - design/exu_alu_top.sv
  - target: simulation
    files:
      - testbench/exu_alu_tb.sv

// ==== testbench/exu_alu_patterns.txt ====
# grp op rs1 rs2 imm pc op2imm rdwen prdt exc wdat rslv, all hex
# grp 0 is ALU and 1 is branch, exc bits are ilegl buserr misalgn
0 0 00000005 00000007 00000000 00001000 0 1 0 0 0000000c 0
0 0 00000010 00000000 fffffffc 00001004 1 1 0 0 0000000c 0
0 1 00000003 00000005 00000000 00001008 0 1 0 0 fffffffe 0
0 2 f0f0f0f0 0ff00ff0 00000000 0000100c 0 1 0 0 ff00ff00 0
0 2 12345678 00000000 000000ff 00001010 1 1 0 0 12345687 0
0 3 00000001 0000001f 00000000 00001014 0 1 0 0 80000000 0
0 4 80000000 00000004 00000000 00001018 0 1 0 0 08000000 0
0 4 f0000000 00000024 00000000 0000101c 0 1 0 0 0f000000 0
0 5 80000000 00000004 00000000 00001020 0 1 0 0 f8000000 0
0 5 7ffffff0 00000000 00000004 00001024 1 1 0 0 07ffffff 0
0 6 00ff0000 000000ff 00000000 00001028 0 1 0 0 00ff00ff 0
0 7 ffff0000 0ff00ff0 00000000 0000102c 0 1 0 0 0ff00000 0
0 8 ffffffff 00000001 00000000 00001030 0 1 0 0 00000001 0
0 8 80000000 00000000 7fffffff 00001034 1 1 0 0 00000001 0
0 9 ffffffff 00000001 00000000 00001038 0 1 0 0 00000000 0
0 9 00000001 ffffffff 00000000 0000103c 0 1 0 0 00000001 0
0 a deadbeef 00000000 12345000 00001040 0 1 0 0 12345000 0
0 b 00000000 00000000 00000000 00001044 0 0 0 0 00000000 0
0 c 00000000 00000000 00000000 00001048 0 0 0 0 00000000 0
0 d 00000000 00000000 00000000 0000104c 0 0 0 0 00000000 0
1 0 00000042 00000042 00000010 00002000 0 0 1 0 00000000 1
1 1 00000042 00000042 00000010 00002004 0 0 1 0 00000000 0
1 2 fffffff0 00000010 00000020 00002008 0 0 0 0 00000000 1
1 3 fffffff0 00000010 00000020 0000200c 0 0 0 0 00000000 0
1 4 fffffff0 00000010 00000020 00002010 0 0 1 0 00000000 0
1 5 fffffff0 00000010 00000020 00002014 0 0 0 0 00000000 1
1 6 00000000 00000000 00000100 00002000 0 1 1 0 00002004 1
1 7 00000000 00000000 00000000 00002018 0 0 0 0 00000000 0
1 8 00000000 00000000 00000000 0000201c 0 0 0 0 00000000 0
1 9 00000000 00000000 00000000 00002020 0 0 0 0 00000000 0
0 0 00000005 00000007 00000000 00003000 0 1 0 4 00000000 0
1 6 00000000 00000000 00000000 00003004 0 1 1 2 00000000 0
0 3 00000001 00000001 00000000 00003008 0 1 0 1 00000000 0

// ==== testbench/exu_alu_tb.sv ====
// ALU execution stage testbench
`timescale 1ns/100ps
`default_nettype none

module exu_alu_tb
  import exu_alu_pkg::*;
();

  localparam int xlen           = 32;
  localparam int max_pat        = 64;
  localparam int cycles_per_pat = 16;
  localparam int reset_cycles   = 8;

  logic clk;
  logic i_reset;
  logic i_valid, o_ready, i_op2imm, i_rdwen, i_bjp_prdt;
  logic i_ilegl, i_buserr, i_misalgn, i_cmt_ready, i_wbck_ready;
  grp_e i_grp;
  alu_op_e i_alu_op;
  bjp_op_e i_bjp_op;
  logic [xlen-1:0] i_rs1, i_rs2, i_imm, i_pc, o_cmt_pc, o_cmt_imm, o_wbck_wdat;
  logic [rfidx_w-1:0] i_rdidx, o_wbck_rdidx;
  logic o_cmt_valid, o_cmt_bjp, o_cmt_bjp_prdt, o_cmt_bjp_rslv, o_cmt_mret, o_cmt_dret;
  logic o_cmt_fencei, o_cmt_ecall, o_cmt_ebreak, o_cmt_wfi, o_cmt_err;
  logic o_cmt_ifu_ilegl, o_cmt_ifu_buserr, o_cmt_ifu_misalgn, o_wbck_valid;

  // Pattern columns
  logic [31:0] pat_grp [0:max_pat-1], pat_op [0:max_pat-1], pat_rs1 [0:max_pat-1];
  logic [31:0] pat_rs2 [0:max_pat-1], pat_imm [0:max_pat-1], pat_pc [0:max_pat-1];
  logic [31:0] pat_o2i [0:max_pat-1], pat_rdwen [0:max_pat-1], pat_prdt [0:max_pat-1];
  logic [31:0] pat_exc [0:max_pat-1], pat_wdat [0:max_pat-1], pat_rslv [0:max_pat-1];

  int n_pat, err_count, pass_tests, fail_tests, commit_count;
  int cycle_count, limit_cycles;
  logic [31:0] lfsr_state;

  exu_alu_top #(.xlen(xlen)) exu_alu_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // Every commit handshake, also while idle
  always @(posedge clk) begin
    if (o_cmt_valid && i_cmt_ready) commit_count <= commit_count + 1;
  end

  ////////////////////
  // Helpers

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) lfsr_step = (s >> 1) ^ 32'h80200003;
    else lfsr_step = s >> 1;
  endfunction

  task automatic take_bit(output logic b);
    b = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
  endtask

  task automatic drive_readies();   // Each ready high 3 times in 4
    logic b0, b1, b2, b3;
    take_bit(b0);
    take_bit(b1);
    take_bit(b2);
    take_bit(b3);
    i_cmt_ready  = b0 | b1;
    i_wbck_ready = b2 | b3;
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic load_patterns();
    int fd;
    int got;
    string line;
    fd = $fopen("testbench/exu_alu_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file");
      err_count++;
    end else begin
      while ($fgets(line, fd) && n_pat < max_pat) begin
        if (line.getc(0) == "#") continue;   // Column description
        got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", pat_grp[n_pat],
                      pat_op[n_pat], pat_rs1[n_pat], pat_rs2[n_pat], pat_imm[n_pat],
                      pat_pc[n_pat], pat_o2i[n_pat], pat_rdwen[n_pat], pat_prdt[n_pat],
                      pat_exc[n_pat], pat_wdat[n_pat], pat_rslv[n_pat]);
        if (got == 12) n_pat++;
        else if (got > 0) begin
          $display("Pattern line has %0d fields instead of 12", got);
          err_count++;
        end
      end
      $fclose(fd);
      if (n_pat == 0) begin
        $display("Pattern file holds no patterns");
        err_count++;
      end
    end
  endtask

  task automatic check_handshake(input logic need);
    check_value("o_wbck_valid", i_valid & need & i_cmt_ready, o_wbck_valid);
    check_value("o_cmt_valid", i_valid & (~need | i_wbck_ready), o_cmt_valid);
    check_value("o_ready", i_cmt_ready & (~need | i_wbck_ready), o_ready);
  endtask

  task automatic check_results(input int k);
    logic excp;
    logic sel_alu;
    logic sel_bjp;
    logic [3:0] op;
    excp    = |pat_exc[k][2:0];
    sel_alu = ~excp & ~pat_grp[k][0];
    sel_bjp = ~excp & pat_grp[k][0];
    op      = pat_op[k][3:0];
    // System ALU ops have no defined result
    if (!(sel_alu && (op == ALU_ECALL || op == ALU_EBREAK || op == ALU_WFI)))
      check_value("o_wbck_wdat", pat_wdat[k], o_wbck_wdat);
    check_value("o_cmt_bjp_rslv", pat_rslv[k][0], o_cmt_bjp_rslv);
    check_value("o_cmt_bjp_prdt", sel_bjp & pat_prdt[k][0], o_cmt_bjp_prdt);
    check_value("o_cmt_bjp", sel_bjp & (op <= BJP_JUMP), o_cmt_bjp);
    check_value("o_cmt_mret", sel_bjp & (op == BJP_MRET), o_cmt_mret);
    check_value("o_cmt_dret", sel_bjp & (op == BJP_DRET), o_cmt_dret);
    check_value("o_cmt_fencei", sel_bjp & (op == BJP_FENCEI), o_cmt_fencei);
    check_value("o_cmt_ecall", sel_alu & (op == ALU_ECALL), o_cmt_ecall);
    check_value("o_cmt_ebreak", sel_alu & (op == ALU_EBREAK), o_cmt_ebreak);
    check_value("o_cmt_wfi", sel_alu & (op == ALU_WFI), o_cmt_wfi);
    check_value("o_cmt_err", excp, o_cmt_err);
    check_value("o_cmt_ifu_ilegl", pat_exc[k][2], o_cmt_ifu_ilegl);
    check_value("o_cmt_ifu_buserr", pat_exc[k][1], o_cmt_ifu_buserr);
    check_value("o_cmt_ifu_misalgn", pat_exc[k][0], o_cmt_ifu_misalgn);
    check_value("o_cmt_pc", pat_pc[k], o_cmt_pc);
    check_value("o_cmt_imm", pat_imm[k], o_cmt_imm);
    check_value("o_wbck_rdidx", i_rdidx, o_wbck_rdidx);
  endtask

  ////////////////////
  // One instruction through both handshakes

  task automatic run_pattern(input int k);
    int errs_before;
    logic need;
    logic done;
    errs_before = err_count;
    need = pat_rdwen[k][0] & ~|pat_exc[k][2:0];
    @(negedge clk);
    i_grp      = grp_e'(pat_grp[k][0]);
    i_alu_op   = pat_grp[k][0] ? ALU_ADD : alu_op_e'(pat_op[k][3:0]);
    i_bjp_op   = pat_grp[k][0] ? bjp_op_e'(pat_op[k][3:0]) : BJP_BEQ;
    i_rs1      = pat_rs1[k];
    i_rs2      = pat_rs2[k];
    i_imm      = pat_imm[k];
    i_pc       = pat_pc[k];
    i_op2imm   = pat_o2i[k][0];
    i_rdwen    = pat_rdwen[k][0];
    i_rdidx    = rfidx_w'(k % 31 + 1);
    i_bjp_prdt = pat_prdt[k][0];
    {i_ilegl, i_buserr, i_misalgn} = pat_exc[k][2:0];
    i_valid    = 1'b1;
    drive_readies();
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      check_handshake(need);
      if (o_cmt_valid && i_cmt_ready) begin
        check_value("wbck transfer", need, o_wbck_valid & i_wbck_ready);
        check_results(k);
        done = 1'b1;
      end else begin
        @(negedge clk);
        drive_readies();        // Fields held, readies redrawn
      end
    end
    if (err_count == errs_before) begin
      $display("test %0d grp %0d op %h ok", k, pat_grp[k][0], pat_op[k][3:0]);
      pass_tests++;
    end else begin
      $display("test %0d grp %0d op %h FAILED", k, pat_grp[k][0], pat_op[k][3:0]);
      fail_tests++;
    end
  endtask

  ////////////////////
  // Timeout

  initial begin
    wait (limit_cycles > 0);
    while (cycle_count < limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles without finishing the patterns", limit_cycles);
    $display("sim failed");
    $finish;
  end

  ////////////////////
  // Main sequence

  initial begin
    i_reset = 1'b1;
    i_valid = 1'b0;
    i_grp = GRP_ALU;
    i_alu_op = ALU_ADD;
    i_bjp_op = BJP_BEQ;
    {i_rs1, i_rs2, i_imm, i_pc} = '0;
    {i_op2imm, i_rdwen, i_bjp_prdt, i_ilegl, i_buserr, i_misalgn} = '0;
    i_rdidx = '0;
    i_cmt_ready = 1'b0;
    i_wbck_ready = 1'b0;
    {n_pat, err_count, pass_tests, fail_tests} = '0;
    limit_cycles = 0;
    lfsr_state = 32'h95a19bb5;
    load_patterns();
    limit_cycles = n_pat * cycles_per_pat + reset_cycles + 32;
    repeat (reset_cycles) begin
      @(posedge clk);
      check_value("o_cmt_valid", 1'b0, o_cmt_valid);   // Idle while i_valid low
      check_value("o_wbck_valid", 1'b0, o_wbck_valid);
    end
    @(negedge clk);
    i_reset = 1'b0;
    for (int k = 0; k < n_pat; k++) run_pattern(k);
    @(negedge clk);
    i_valid = 1'b0;
    repeat (2) @(negedge clk);   // Idle cycles must not commit
    check_value("commit count", n_pat, commit_count);
    $display("tests %0d passed %0d failed, %0d errors", pass_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/exu_alu_top.sv ====
// Execution stage ALU
`timescale 1ns/100ps
`default_nettype none

module exu_alu_top
  import exu_alu_pkg::*;
#(
  parameter int xlen = 32
) (
  input  logic               i_valid,
  output logic               o_ready,
  input  grp_e               i_grp,
  input  alu_op_e            i_alu_op,
  input  bjp_op_e            i_bjp_op,
  input  logic [xlen-1:0]    i_rs1,
  input  logic [xlen-1:0]    i_rs2,
  input  logic [xlen-1:0]    i_imm,
  input  logic [xlen-1:0]    i_pc,
  input  logic               i_op2imm,
  input  logic [rfidx_w-1:0] i_rdidx,
  input  logic               i_rdwen,
  input  logic               i_bjp_prdt,
  input  logic               i_ilegl,
  input  logic               i_buserr,
  input  logic               i_misalgn,

  // Commit port
  output logic               o_cmt_valid,
  input  logic               i_cmt_ready,
  output logic [xlen-1:0]    o_cmt_pc,
  output logic [xlen-1:0]    o_cmt_imm,
  output logic               o_cmt_bjp,
  output logic               o_cmt_bjp_prdt,
  output logic               o_cmt_bjp_rslv,
  output logic               o_cmt_mret,
  output logic               o_cmt_dret,
  output logic               o_cmt_fencei,
  output logic               o_cmt_ecall,
  output logic               o_cmt_ebreak,
  output logic               o_cmt_wfi,
  output logic               o_cmt_err,
  output logic               o_cmt_ifu_ilegl,
  output logic               o_cmt_ifu_buserr,
  output logic               o_cmt_ifu_misalgn,

  // Write-back port
  output logic               o_wbck_valid,
  input  logic               i_wbck_ready,
  output logic [xlen-1:0]    o_wbck_wdat,
  output logic [rfidx_w-1:0] o_wbck_rdidx
);

  logic [xlen-1:0] rglr_op1;
  logic [xlen-1:0] rglr_op2;
  dpath_op_e       rglr_dop;
  logic            rglr_ecall;
  logic            rglr_ebreak;
  logic            rglr_wfi;
  logic [xlen-1:0] bjp_op1;
  logic [xlen-1:0] bjp_op2;
  dpath_op_e       bjp_dop;
  logic            bjp_cmt_bjp;
  logic            bjp_rslv;
  logic            bjp_mret;
  logic            bjp_dret;
  logic            bjp_fencei;
  logic            sel_bjp;
  logic [xlen-1:0] dpath_res;
  logic            dpath_cmp;

  ////////////////////
  // Commit pass-through

  assign o_cmt_pc          = i_pc;
  assign o_cmt_imm         = i_imm;
  assign o_wbck_rdidx      = i_rdidx;
  assign o_cmt_ifu_ilegl   = i_ilegl;
  assign o_cmt_ifu_buserr  = i_buserr;
  assign o_cmt_ifu_misalgn = i_misalgn;

  ////////////////////
  // Units

  exu_alu_rglr #(
    .xlen (xlen)
  ) exu_alu_rglr_inst (
    .i_alu_op (i_alu_op),
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .i_imm    (i_imm),
    .i_op2imm (i_op2imm),
    .o_op1    (rglr_op1),
    .o_op2    (rglr_op2),
    .o_dop    (rglr_dop),
    .o_ecall  (rglr_ecall),
    .o_ebreak (rglr_ebreak),
    .o_wfi    (rglr_wfi)
  );

  exu_alu_bjp #(
    .xlen (xlen)
  ) exu_alu_bjp_inst (
    .i_bjp_op    (i_bjp_op),
    .i_rs1       (i_rs1),
    .i_rs2       (i_rs2),
    .i_pc        (i_pc),
    .i_dpath_cmp (dpath_cmp),
    .o_op1       (bjp_op1),
    .o_op2       (bjp_op2),
    .o_dop       (bjp_dop),
    .o_cmt_bjp   (bjp_cmt_bjp),
    .o_rslv      (bjp_rslv),
    .o_mret      (bjp_mret),
    .o_dret      (bjp_dret),
    .o_fencei    (bjp_fencei)
  );

  exu_alu_dpath #(
    .xlen (xlen)
  ) exu_alu_dpath_inst (
    .i_sel_bjp  (sel_bjp),
    .i_rglr_op1 (rglr_op1),
    .i_rglr_op2 (rglr_op2),
    .i_rglr_dop (rglr_dop),
    .i_bjp_op1  (bjp_op1),
    .i_bjp_op2  (bjp_op2),
    .i_bjp_dop  (bjp_dop),
    .o_res      (dpath_res),
    .o_cmp      (dpath_cmp)
  );

  exu_alu_ctrl #(
    .xlen (xlen)
  ) exu_alu_ctrl_inst (
    .i_valid        (i_valid),
    .i_grp          (i_grp),
    .i_ilegl        (i_ilegl),
    .i_buserr       (i_buserr),
    .i_misalgn      (i_misalgn),
    .i_rdwen        (i_rdwen),
    .i_bjp_op       (i_bjp_op),
    .i_bjp_prdt     (i_bjp_prdt),
    .i_dpath_res    (dpath_res),
    .i_rglr_ecall   (rglr_ecall),
    .i_rglr_ebreak  (rglr_ebreak),
    .i_rglr_wfi     (rglr_wfi),
    .i_bjp_cmt_bjp  (bjp_cmt_bjp),
    .i_bjp_rslv     (bjp_rslv),
    .i_bjp_mret     (bjp_mret),
    .i_bjp_dret     (bjp_dret),
    .i_bjp_fencei   (bjp_fencei),
    .i_cmt_ready    (i_cmt_ready),
    .i_wbck_ready   (i_wbck_ready),
    .o_ready        (o_ready),
    .o_cmt_valid    (o_cmt_valid),
    .o_wbck_valid   (o_wbck_valid),
    .o_sel_bjp      (sel_bjp),
    .o_wbck_wdat    (o_wbck_wdat),
    .o_cmt_err      (o_cmt_err),
    .o_cmt_bjp      (o_cmt_bjp),
    .o_cmt_bjp_prdt (o_cmt_bjp_prdt),
    .o_cmt_bjp_rslv (o_cmt_bjp_rslv),
    .o_cmt_mret     (o_cmt_mret),
    .o_cmt_dret     (o_cmt_dret),
    .o_cmt_fencei   (o_cmt_fencei),
    .o_cmt_ecall    (o_cmt_ecall),
    .o_cmt_ebreak   (o_cmt_ebreak),
    .o_cmt_wfi      (o_cmt_wfi)
  );

endmodule

`default_nettype wire

// ==== design/exu_alu_ctrl.sv ====
// ALU result arbitration and handshake
`timescale 1ns/100ps
`default_nettype none

module exu_alu_ctrl
  import exu_alu_pkg::*;
#(
  parameter int xlen = 32
) (
  // Instruction from dispatch
  input  logic            i_valid,
  input  grp_e            i_grp,
  input  logic            i_ilegl,
  input  logic            i_buserr,
  input  logic            i_misalgn,
  input  logic            i_rdwen,
  input  bjp_op_e         i_bjp_op,
  input  logic            i_bjp_prdt,

  // Shared datapath result
  input  logic [xlen-1:0] i_dpath_res,

  // Commit flags from the two units
  input  logic            i_rglr_ecall,
  input  logic            i_rglr_ebreak,
  input  logic            i_rglr_wfi,
  input  logic            i_bjp_cmt_bjp,
  input  logic            i_bjp_rslv,
  input  logic            i_bjp_mret,
  input  logic            i_bjp_dret,
  input  logic            i_bjp_fencei,

  // Downstream readies
  input  logic            i_cmt_ready,
  input  logic            i_wbck_ready,

  output logic            o_ready,
  output logic            o_cmt_valid,
  output logic            o_wbck_valid,
  output logic            o_sel_bjp,      // Datapath requester select
  output logic [xlen-1:0] o_wbck_wdat,
  output logic            o_cmt_err,
  output logic            o_cmt_bjp,
  output logic            o_cmt_bjp_prdt,
  output logic            o_cmt_bjp_rslv,
  output logic            o_cmt_mret,
  output logic            o_cmt_dret,
  output logic            o_cmt_fencei,
  output logic            o_cmt_ecall,
  output logic            o_cmt_ebreak,
  output logic            o_cmt_wfi
);

  logic excp;
  logic sel_alu;
  logic sel_bjp;
  logic bjp_link;
  logic need_wbck;

  ////////////////////
  // Group select

  // Fetch exceptions bypass both units
  assign excp    = i_ilegl | i_buserr | i_misalgn;
  assign sel_alu = ~excp & (i_grp == GRP_ALU);
  assign sel_bjp = ~excp & (i_grp == GRP_BJP);

  assign o_sel_bjp = sel_bjp;

  ////////////////////
  // Result merge

  assign bjp_link    = sel_bjp & (i_bjp_op == BJP_JUMP);  // Jump writes link address
  assign o_wbck_wdat = {xlen{sel_alu | bjp_link}} & i_dpath_res;
  assign o_cmt_err   = excp;

  assign o_cmt_bjp      = sel_bjp & i_bjp_cmt_bjp;
  assign o_cmt_bjp_prdt = sel_bjp & i_bjp_prdt;
  assign o_cmt_bjp_rslv = sel_bjp & i_bjp_rslv;
  assign o_cmt_mret     = sel_bjp & i_bjp_mret;
  assign o_cmt_dret     = sel_bjp & i_bjp_dret;
  assign o_cmt_fencei   = sel_bjp & i_bjp_fencei;
  assign o_cmt_ecall    = sel_alu & i_rglr_ecall;
  assign o_cmt_ebreak   = sel_alu & i_rglr_ebreak;
  assign o_cmt_wfi      = sel_alu & i_rglr_wfi;

  ////////////////////
  // Commit and write-back handshake

  // Every instruction commits, only error-free rd writes go to write-back.
  // Each valid waits on the other side's ready so both fire together.
  assign need_wbck    = i_rdwen & ~o_cmt_err;
  assign o_wbck_valid = i_valid & need_wbck & i_cmt_ready;
  assign o_cmt_valid  = i_valid & (~need_wbck | i_wbck_ready);
  assign o_ready      = i_cmt_ready & (~need_wbck | i_wbck_ready);

endmodule

`default_nettype wire

// ==== design/exu_alu_dpath.sv ====
// Shared ALU datapath
`timescale 1ns/100ps
`default_nettype none

module exu_alu_dpath
  import exu_alu_pkg::*;
#(
  parameter int xlen = 32
) (
  input  logic            i_sel_bjp,    // Branch unit owns the datapath
  input  logic [xlen-1:0] i_rglr_op1,
  input  logic [xlen-1:0] i_rglr_op2,
  input  dpath_op_e       i_rglr_dop,
  input  logic [xlen-1:0] i_bjp_op1,
  input  logic [xlen-1:0] i_bjp_op2,
  input  dpath_op_e       i_bjp_dop,

  output logic [xlen-1:0] o_res,
  output logic            o_cmp
);

  localparam int shamt_w = $clog2(xlen);

  logic [xlen-1:0]    op1;
  logic [xlen-1:0]    op2;
  dpath_op_e          dop;
  logic               do_sub;
  logic               do_signed;
  logic [xlen:0]      add_a;
  logic [xlen:0]      add_b;
  logic [xlen:0]      add_res;
  logic [xlen-1:0]    xor_res;
  logic [shamt_w-1:0] shamt;
  logic [xlen-1:0]    sll_res;
  logic [xlen-1:0]    srl_res;
  logic [xlen-1:0]    sra_res;
  logic               lt;
  logic               eq;

  ////////////////////
  // Request mux

  assign op1 = i_sel_bjp ? i_bjp_op1 : i_rglr_op1;
  assign op2 = i_sel_bjp ? i_bjp_op2 : i_rglr_op2;
  assign dop = i_sel_bjp ? i_bjp_dop : i_rglr_dop;

  ////////////////////
  // Adder

  // Less-than ops all subtract
  assign do_sub = (dop == DOP_SUB) | (dop == DOP_SLT) | (dop == DOP_SLTU)
                | (dop == DOP_CMP_LT) | (dop == DOP_CMP_LTU);
  assign do_signed = (dop == DOP_SLT) | (dop == DOP_CMP_LT);

  // One extra bit, sign or zero extended, holds the true sign of a - b
  assign add_a   = {do_signed & op1[xlen-1], op1};
  assign add_b   = {do_signed & op2[xlen-1], op2} ^ {(xlen + 1){do_sub}};
  assign add_res = add_a + add_b + {{xlen{1'b0}}, do_sub};

  assign lt = add_res[xlen];

  ////////////////////
  // Logic and shifter

  assign xor_res = op1 ^ op2;
  assign eq      = ~|xor_res;     // Equal when no bit differs

  assign shamt   = op2[shamt_w-1:0];
  assign sll_res = op1 << shamt;
  assign srl_res = op1 >> shamt;
  assign sra_res = $signed(op1) >>> shamt;

  ////////////////////
  // Result select

  always_comb begin
    case (dop)
      DOP_ADD:   o_res = add_res[xlen-1:0];
      DOP_SUB:   o_res = add_res[xlen-1:0];
      DOP_XOR:   o_res = xor_res;
      DOP_OR:    o_res = op1 | op2;
      DOP_AND:   o_res = op1 & op2;
      DOP_SLL:   o_res = sll_res;
      DOP_SRL:   o_res = srl_res;
      DOP_SRA:   o_res = sra_res;
      DOP_SLT:   o_res = {{(xlen - 1){1'b0}}, lt};
      DOP_SLTU:  o_res = {{(xlen - 1){1'b0}}, lt};
      DOP_PASS2: o_res = op2;
      default:   o_res = '0;
    endcase
  end

  always_comb begin
    case (dop)
      DOP_CMP_EQ:  o_cmp = eq;
      DOP_CMP_NE:  o_cmp = ~eq;
      DOP_CMP_LT:  o_cmp = lt;
      DOP_CMP_LTU: o_cmp = lt;
      default:     o_cmp = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/exu_alu_bjp.sv ====
// Branch and jump unit
`timescale 1ns/100ps
`default_nettype none

module exu_alu_bjp
  import exu_alu_pkg::*;
#(
  parameter int xlen = 32
) (
  input  bjp_op_e         i_bjp_op,
  input  logic [xlen-1:0] i_rs1,
  input  logic [xlen-1:0] i_rs2,
  input  logic [xlen-1:0] i_pc,
  input  logic            i_dpath_cmp,

  output logic [xlen-1:0] o_op1,
  output logic [xlen-1:0] o_op2,
  output dpath_op_e       o_dop,
  output logic            o_cmt_bjp,
  output logic            o_rslv,
  output logic            o_mret,
  output logic            o_dret,
  output logic            o_fencei
);

  localparam logic [xlen-1:0] instr_bytes = xlen / 8;

  logic is_jump;

  assign is_jump = (i_bjp_op == BJP_JUMP);

  // Link address is pc plus instruction size
  assign o_op1 = is_jump ? i_pc : i_rs1;
  assign o_op2 = is_jump ? instr_bytes : i_rs2;

  ////////////////////
  // Compare request and resolve

  always_comb begin
    o_dop     = DOP_CMP_EQ;
    o_cmt_bjp = 1'b1;
    o_rslv    = i_dpath_cmp;
    o_mret    = 1'b0;
    o_dret    = 1'b0;
    o_fencei  = 1'b0;
    case (i_bjp_op)
      BJP_BEQ:  o_dop = DOP_CMP_EQ;
      BJP_BNE:  o_dop = DOP_CMP_NE;
      BJP_BLT:  o_dop = DOP_CMP_LT;
      BJP_BLTU: o_dop = DOP_CMP_LTU;
      BJP_BGE: begin
        o_dop  = DOP_CMP_LT;       // Taken when not less
        o_rslv = ~i_dpath_cmp;
      end
      BJP_BGEU: begin
        o_dop  = DOP_CMP_LTU;
        o_rslv = ~i_dpath_cmp;
      end
      BJP_JUMP: begin
        o_dop  = DOP_ADD;
        o_rslv = 1'b1;             // Always taken
      end
      default: begin
        // mret, dret, fence.i are not branches
        o_cmt_bjp = 1'b0;
        o_rslv    = 1'b0;
        o_mret    = (i_bjp_op == BJP_MRET);
        o_dret    = (i_bjp_op == BJP_DRET);
        o_fencei  = (i_bjp_op == BJP_FENCEI);
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/exu_alu_rglr.sv ====
// Regular ALU decoder
`timescale 1ns/100ps
`default_nettype none

module exu_alu_rglr
  import exu_alu_pkg::*;
#(
  parameter int xlen = 32
) (
  input  alu_op_e         i_alu_op,
  input  logic [xlen-1:0] i_rs1,
  input  logic [xlen-1:0] i_rs2,
  input  logic [xlen-1:0] i_imm,
  input  logic            i_op2imm,   // Operand 2 from immediate

  output logic [xlen-1:0] o_op1,
  output logic [xlen-1:0] o_op2,
  output dpath_op_e       o_dop,
  output logic            o_ecall,
  output logic            o_ebreak,
  output logic            o_wfi
);

  assign o_op1 = i_rs1;

  // LUI always takes the immediate
  assign o_op2 = (i_op2imm || (i_alu_op == ALU_LUI)) ? i_imm : i_rs2;

  ////////////////////
  // Opcode map

  always_comb begin
    o_dop    = DOP_ADD;
    o_ecall  = 1'b0;
    o_ebreak = 1'b0;
    o_wfi    = 1'b0;
    case (i_alu_op)
      ALU_ADD:    o_dop = DOP_ADD;
      ALU_SUB:    o_dop = DOP_SUB;
      ALU_XOR:    o_dop = DOP_XOR;
      ALU_SLL:    o_dop = DOP_SLL;
      ALU_SRL:    o_dop = DOP_SRL;
      ALU_SRA:    o_dop = DOP_SRA;
      ALU_OR:     o_dop = DOP_OR;
      ALU_AND:    o_dop = DOP_AND;
      ALU_SLT:    o_dop = DOP_SLT;
      ALU_SLTU:   o_dop = DOP_SLTU;
      ALU_LUI:    o_dop = DOP_PASS2;
      // System ops only flag the commit stage
      ALU_ECALL:  o_ecall = 1'b1;
      ALU_EBREAK: o_ebreak = 1'b1;
      ALU_WFI:    o_wfi = 1'b1;
      default: begin
        o_dop = DOP_ADD;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/exu_alu_pkg.sv ====
// ALU shared types
`default_nettype none

package exu_alu_pkg;

  // Register file index width
  localparam int rfidx_w = 5;

  ////////////////////
  // Instruction group

  typedef enum logic {
    GRP_ALU = 1'b0,
    GRP_BJP = 1'b1
  } grp_e;

  ////////////////////
  // Regular ALU opcodes

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_XOR    = 4'd2,
    ALU_SLL    = 4'd3,
    ALU_SRL    = 4'd4,
    ALU_SRA    = 4'd5,
    ALU_OR     = 4'd6,
    ALU_AND    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    ALU_LUI    = 4'd10,
    ALU_ECALL  = 4'd11,
    ALU_EBREAK = 4'd12,
    ALU_WFI    = 4'd13
  } alu_op_e;

  ////////////////////
  // Branch and jump opcodes

  typedef enum logic [3:0] {
    BJP_BEQ    = 4'd0,
    BJP_BNE    = 4'd1,
    BJP_BLT    = 4'd2,
    BJP_BGE    = 4'd3,
    BJP_BLTU   = 4'd4,
    BJP_BGEU   = 4'd5,
    BJP_JUMP   = 4'd6,
    BJP_MRET   = 4'd7,
    BJP_DRET   = 4'd8,
    BJP_FENCEI = 4'd9
  } bjp_op_e;

  ////////////////////
  // Shared datapath operations

  typedef enum logic [3:0] {
    DOP_ADD     = 4'd0,
    DOP_SUB     = 4'd1,
    DOP_XOR     = 4'd2,
    DOP_OR      = 4'd3,
    DOP_AND     = 4'd4,
    DOP_SLL     = 4'd5,
    DOP_SRL     = 4'd6,
    DOP_SRA     = 4'd7,
    DOP_SLT     = 4'd8,
    DOP_SLTU    = 4'd9,
    DOP_CMP_EQ  = 4'd10,
    DOP_CMP_NE  = 4'd11,
    DOP_CMP_LT  = 4'd12,
    DOP_CMP_LTU = 4'd13,
    DOP_PASS2   = 4'd14
  } dpath_op_e;

endpackage

`default_nettype wire
